// File: source/div_pkg.sv
/*
 * Shared constants, one-hot state indices and bus types for the
 * sequential divider and the shared writeback port.
 * Imported by every RTL block of the divide unit.
 */
package div_pkg;

   ////////////////////////////////////////////////////////////
   // Divider sizing
   ////////////////////////////////////////////////////////////
   // One quotient bit per run cycle
   localparam int div_iters = 64;
   localparam int cnt_w     = 6;
   // Architectural result width
   localparam int data_w    = 32;

   ////////////////////////////////////////////////////////////
   // One-hot state bit positions
   ////////////////////////////////////////////////////////////
   localparam int st_idle  = 0;
   localparam int st_run   = 1;
   localparam int st_last  = 2;
   localparam int st_chk   = 3;
   localparam int st_fix   = 4;
   localparam int st_done  = 5;
   localparam int n_states = 6;

   // Clamp values for overflowed quotients
   localparam logic [31:0] umax32     = 32'hffff_ffff;
   localparam logic [31:0] spos_max32 = 32'h7fff_ffff;
   localparam logic [31:0] sneg_min32 = 32'h8000_0000;

   ////////////////////////////////////////////////////////////
   // Bus types
   ////////////////////////////////////////////////////////////
   // Divide request, 97 bits
   typedef struct packed {
      logic [63:0] dividend;
      logic [31:0] divisor;
      logic        is_signed;
   } div_req_t;

   // SPARC condition codes
   typedef struct packed {
      logic n;
      logic z;
      logic v;
      logic c;
   } cc_t;

   // Datapath result: unsigned quotient plus sign, 66 bits
   typedef struct packed {
      logic [63:0] mag;
      logic        neg;
      logic        is_signed;
   } div_raw_t;

   // Writeback payload, 73 bits
   typedef struct packed {
      logic [63:0] data;
      cc_t         xcc;
      cc_t         icc;
      logic        from_div;
   } wb_bus_t;

endpackage

// File: source/div_ctl_fsm.sv
/*
 * Control for the divider: one-hot state machine plus a 6-bit
 * iteration counter. Produces datapath strobes and arbitration hints.
 */
`timescale 1ns/1ps

module div_ctl_fsm (
   input  logic clk,
   input  logic rst_n,
   input  logic div_start,
   input  logic div_kill,
   input  logic div_ack,
   output logic ld,
   output logic step,
   output logic last,
   output logic chk,
   output logic div_busy,
   output logic div_late,
   output logic div_done
);
   import div_pkg::*;

   logic [n_states-1:0] state;
   logic [n_states-1:0] next_state;
   logic [cnt_w-1:0]    cnt;
   logic                cnt_last;
   logic                stay_idle;
   logic                go_idle;
   logic                go_run;
   logic                stay_run;
   logic                go_last;
   logic                stay_done;

   ////////////////////////////////////////////////////////////
   // Next state
   ////////////////////////////////////////////////////////////
   assign stay_idle = state[st_idle] & ~div_start;
   assign go_idle   = state[st_done] & div_ack;
   assign go_run    = state[st_idle] & div_start;
   assign stay_run  = state[st_run] & ~cnt_last;
   assign go_last   = state[st_run] & cnt_last;
   // Result waits here until the port acknowledges it
   assign stay_done = state[st_done] & ~div_ack;

   // Kill wins over every other transition
   assign next_state[st_idle] = stay_idle | go_idle | div_kill;
   assign next_state[st_run]  = (go_run | stay_run) & ~div_kill;
   assign next_state[st_last] = go_last & ~div_kill;
   // Check and fix are fixed single-cycle stages
   assign next_state[st_chk]  = state[st_last] & ~div_kill;
   assign next_state[st_fix]  = state[st_chk] & ~div_kill;
   assign next_state[st_done] = (state[st_fix] | stay_done) & ~div_kill;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         state <= n_states'(1 << st_idle);
      end else begin
         state <= next_state;
      end
   end

   ////////////////////////////////////////////////////////////
   // Iteration counter
   ////////////////////////////////////////////////////////////
   // Held at zero outside run so each divide starts clean
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         cnt <= '0;
      end else if (!state[st_run]) begin
         cnt <= '0;
      end else begin
         cnt <= cnt + 1'b1;
      end
   end

   // Final quotient step
   assign cnt_last = (cnt == cnt_w'(div_iters - 1));

   ////////////////////////////////////////////////////////////
   // State decode
   ////////////////////////////////////////////////////////////
   assign ld       = go_run;
   assign step     = state[st_run];
   assign last     = state[st_last];
   assign chk      = state[st_chk];
   assign div_busy = ~state[st_idle];
   // Divider claims the port from check onward
   assign div_late = state[st_chk] | state[st_fix] | state[st_done];
   assign div_done = state[st_done];

endmodule

// File: source/div_iter_dp.sv
/*
 * Divider datapath. Loads operand magnitudes, runs 64 non-restoring
 * steps with +1/-1 quotient digits and converts them in the last cycle.
 */
`timescale 1ns/1ps

module div_iter_dp (
   input  logic             clk,
   input  logic             rst_n,
   input  logic             ld,
   input  logic             step,
   input  logic             last,
   input  div_pkg::div_req_t req,
   output div_pkg::div_raw_t raw
);
   import div_pkg::*;

   logic        dvd_neg;
   logic        dvs_neg;
   logic [63:0] dvd_mag;
   logic [31:0] dvs_mag;
   // Dividend bits leave the top, quotient digits enter the bottom
   logic [63:0] qx;
   // Partial remainder, two's complement, 34 bits
   logic [33:0] rem;
   logic [33:0] rem_shift;
   logic [33:0] rem_next;
   logic [31:0] dvs;
   logic        sub;
   logic        neg_q;
   logic        signed_q;

   ////////////////////////////////////////////////////////////
   // Operand magnitudes
   ////////////////////////////////////////////////////////////
   assign dvd_neg = req.is_signed & req.dividend[63];
   assign dvs_neg = req.is_signed & req.divisor[31];
   // Largest negative maps to 2^63, still fits unsigned
   assign dvd_mag = dvd_neg ? -req.dividend : req.dividend;
   assign dvs_mag = dvs_neg ? -req.divisor : req.divisor;

   ////////////////////////////////////////////////////////////
   // Non-restoring step
   ////////////////////////////////////////////////////////////
   // Shift remainder left, bring in next dividend bit
   assign rem_shift = {rem[32:0], qx[63]};
   // Subtract while remainder is non-negative, add otherwise
   assign rem_next  = sub ? (rem_shift - {2'b00, dvs})
                          : (rem_shift + {2'b00, dvs});

   // Payload registers
   always_ff @(posedge clk) begin
      if (ld) begin
         qx  <= dvd_mag;
         rem <= '0;
         dvs <= dvs_mag;
      end else if (step) begin
         rem <= rem_next;
         // Digit +1 recorded as 1, -1 as 0
         qx  <= {qx[62:0], sub};
      end else if (last) begin
         // Q = 2P - (2^64 - 1), minus one if remainder ended negative
         qx  <= {qx[62:0], 1'b1} - {63'd0, rem[33]};
      end
   end

   // Control flops
   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         sub      <= 1'b1;
         neg_q    <= 1'b0;
         signed_q <= 1'b0;
      end else if (ld) begin
         // First step always subtracts from a zero remainder
         sub      <= 1'b1;
         neg_q    <= dvd_neg ^ dvs_neg;
         signed_q <= req.is_signed;
      end else if (step) begin
         sub      <= ~rem_next[33];
      end
   end

   // Valid from the check state until the next load
   assign raw = '{mag: qx, neg: neg_q, is_signed: signed_q};

endmodule

// File: source/div_ovfl_cc.sv
/*
 * Overflow check and condition code generation for the divider.
 * Flags are captured in the check state, result and codes in fix.
 */
`timescale 1ns/1ps

module div_ovfl_cc (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              chk,
   input  div_pkg::div_raw_t raw,
   output div_pkg::wb_bus_t  div_res
);
   import div_pkg::*;

   logic              unsign_ovfl;
   logic              pos_ovfl;
   logic              neg_ovfl;
   logic              unsign_ovfl_q;
   logic              pos_ovfl_q;
   logic              neg_ovfl_q;
   logic              fix_q;
   logic              any_ovfl;
   logic [63:0]       quo64;
   logic [data_w-1:0] quo32;
   wb_bus_t           res_d;

   ////////////////////////////////////////////////////////////
   // Overflow tests on the magnitude
   ////////////////////////////////////////////////////////////
   // Unsigned: anything at or above 2^32
   assign unsign_ovfl = ~raw.is_signed & (|raw.mag[63:32]);
   // Positive: at or above 2^31, catches largest negative / -1
   assign pos_ovfl    = raw.is_signed & ~raw.neg & (|raw.mag[63:31]);
   // Negative: strictly above 2^31
   assign neg_ovfl    = raw.is_signed & raw.neg &
                        ((|raw.mag[63:32]) | (raw.mag[31] & (|raw.mag[30:0])));

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         unsign_ovfl_q <= 1'b0;
         pos_ovfl_q    <= 1'b0;
         neg_ovfl_q    <= 1'b0;
         fix_q         <= 1'b0;
      end else begin
         // Fix stage follows check by one cycle
         fix_q <= chk;
         if (chk) begin
            unsign_ovfl_q <= unsign_ovfl;
            pos_ovfl_q    <= pos_ovfl;
            neg_ovfl_q    <= neg_ovfl;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Clamp and codes
   ////////////////////////////////////////////////////////////
   assign any_ovfl = unsign_ovfl_q | pos_ovfl_q | neg_ovfl_q;
   // Reapply the sign
   assign quo64    = raw.neg ? -raw.mag : raw.mag;

   always_comb begin
      if (unsign_ovfl_q) begin
         quo32 = umax32;
      end else if (pos_ovfl_q) begin
         quo32 = spos_max32;
      end else if (neg_ovfl_q) begin
         quo32 = sneg_min32;
      end else begin
         quo32 = quo64[data_w-1:0];
      end
   end

   always_comb begin
      res_d.data     = {32'd0, quo32};
      res_d.icc.n    = quo32[data_w-1];
      res_d.icc.z    = ~(|quo32);
      res_d.icc.v    = any_ovfl;
      res_d.icc.c    = 1'b0;
      // 64-bit codes see the unclamped quotient
      res_d.xcc.n    = raw.neg & (|raw.mag);
      res_d.xcc.z    = ~(|raw.mag);
      res_d.xcc.v    = 1'b0;
      res_d.xcc.c    = 1'b0;
      res_d.from_div = 1'b1;
   end

   // Held through done until the next divide reaches fix
   always_ff @(posedge clk) begin
      if (fix_q) begin
         div_res <= res_d;
      end
   end

endmodule

// File: source/wb_arbiter.sv
/*
 * Writeback port arbiter between the divider and the external
 * multiplier. A late divide holds off the multiplier.
 */
`timescale 1ns/1ps

module wb_arbiter (
   input  logic             div_done,
   input  logic             div_late,
   input  div_pkg::wb_bus_t div_res,
   input  logic             mul_done,
   input  logic [63:0]      mul_data,
   input  logic             wb_ack,
   output logic             wb_req,
   output div_pkg::wb_bus_t wb,
   output logic             mul_stall,
   output logic             div_ack
);
   import div_pkg::*;

   wb_bus_t mul_bus;

   // Multiply result carries no codes
   assign mul_bus = '{data: mul_data, xcc: '0, icc: '0, from_div: 1'b0};

   // Divider owns the port in done, multiplier otherwise
   assign wb_req    = div_done | (mul_done & ~div_late);
   // Multiplier waits once the divide is past its last step
   assign mul_stall = mul_done & div_late;
   assign wb        = div_done ? div_res : mul_bus;
   // Ack only reaches the divider while it owns the port
   assign div_ack   = wb_ack & div_done;

endmodule

// File: source/div_unit_top.sv
/*
 * Divide unit top level. Connects control, datapath, overflow and
 * code logic, and the shared writeback arbiter.
 */
`timescale 1ns/1ps

module div_unit_top (
   input  logic              clk,
   input  logic              rst_n,
   input  logic              div_start,
   input  div_pkg::div_req_t req,
   input  logic              div_kill,
   input  logic              mul_done,
   input  logic [63:0]       mul_data,
   input  logic              wb_ack,
   output logic              div_busy,
   output logic              mul_stall,
   output logic              wb_req,
   output div_pkg::wb_bus_t  wb
);
   import div_pkg::*;

   logic     ld;
   logic     step;
   logic     last;
   logic     chk;
   logic     div_late;
   logic     div_done;
   logic     div_ack;
   div_raw_t raw;
   wb_bus_t  div_res;

   // Sequencing
   div_ctl_fsm div_ctl_fsm_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .div_start (div_start),
      .div_kill  (div_kill),
      .div_ack   (div_ack),
      .ld        (ld),
      .step      (step),
      .last      (last),
      .chk       (chk),
      .div_busy  (div_busy),
      .div_late  (div_late),
      .div_done  (div_done)
   );

   // Quotient magnitude
   div_iter_dp div_iter_dp_inst (
      .clk   (clk),
      .rst_n (rst_n),
      .ld    (ld),
      .step  (step),
      .last  (last),
      .req   (req),
      .raw   (raw)
   );

   // Clamp and codes
   div_ovfl_cc div_ovfl_cc_inst (
      .clk     (clk),
      .rst_n   (rst_n),
      .chk     (chk),
      .raw     (raw),
      .div_res (div_res)
   );

   wb_arbiter wb_arbiter_inst (
      .div_done  (div_done),
      .div_late  (div_late),
      .div_res   (div_res),
      .mul_done  (mul_done),
      .mul_data  (mul_data),
      .wb_ack    (wb_ack),
      .wb_req    (wb_req),
      .wb        (wb),
      .mul_stall (mul_stall),
      .div_ack   (div_ack)
   );

endmodule

// File: testbench/div_unit_chk.sv
/*
 * Concurrent checks on the divide control machine.
 * Bound into every div_ctl_fsm instance from this file.
 */
`timescale 1ns/1ps

module div_unit_chk (
   input logic                         clk,
   input logic                         rst_n,
   input logic [div_pkg::n_states-1:0] state,
   input logic                         ld,
   input logic                         div_done,
   input logic                         div_busy
);
   import div_pkg::*;

   // Edges since the last load, saturating
   logic [7:0] since_ld;

   always_ff @(posedge clk or negedge rst_n) begin
      if (!rst_n) begin
         since_ld <= '0;
      end else if (ld) begin
         since_ld <= '0;
      end else if (since_ld != 8'hff) begin
         since_ld <= since_ld + 8'd1;
      end
   end

   ////////////////////////////////////////////////////////////
   // Properties
   ////////////////////////////////////////////////////////////
   onehot_state : assert property (@(posedge clk) disable iff (!rst_n) $onehot(state))
      else $error("divide state vector is not one-hot");

   // 64 run cycles, last, check and fix come before done
   done_latency : assert property (@(posedge clk) disable iff (!rst_n)
      $rose(div_done) |-> since_ld >= 8'(div_iters + 3))
      else $error("div_done rose too soon after load");

   idle_after_reset : assert property (@(posedge clk) $rose(rst_n) |-> !div_busy)
      else $error("div_busy high after reset");

endmodule

bind div_ctl_fsm div_unit_chk div_unit_chk_inst (
   .clk      (clk),
   .rst_n    (rst_n),
   .state    (state),
   .ld       (ld),
   .div_done (div_done),
   .div_busy (div_busy)
);

// File: testbench/tb_div_unit.sv
/*
 * Testbench for the divide unit. Drives divides and multiply results,
 * models the expected quotient and codes, checks writeback and timing.
 */
`timescale 1ns/1ps

module tb_div_unit;
   import div_pkg::*;

   localparam int n_divs      = 80;
   localparam int timeout_cyc = n_divs * 80 + 2000;
   // Sampling edge to done: 64 run cycles, last, check, fix
   localparam int wb_lat      = div_iters + 3;

   logic        clk;
   logic        rst_n;
   logic        div_start;
   div_req_t    req;
   logic        div_kill;
   logic        mul_done;
   logic [63:0] mul_data;
   logic        wb_ack;
   logic        div_busy;
   logic        mul_stall;
   logic        wb_req;
   wb_bus_t     wb;

   // Port acks from the divide responder and the multiply stimulus
   logic        div_wb_ack;
   logic        mul_wb_ack;
   int          ack_delay = 0;
   int          cyc = 0;
   int          errors = 0;
   int          checks = 0;
   int          results = 0;
   bit          res_seen = 1'b0;
   wb_bus_t     exp_q[$];
   int          start_q[$];

   assign wb_ack = div_wb_ack | mul_wb_ack;

   div_unit_top div_unit_top_inst (
      .clk       (clk),
      .rst_n     (rst_n),
      .div_start (div_start),
      .req       (req),
      .div_kill  (div_kill),
      .mul_done  (mul_done),
      .mul_data  (mul_data),
      .wb_ack    (wb_ack),
      .div_busy  (div_busy),
      .mul_stall (mul_stall),
      .wb_req    (wb_req),
      .wb        (wb)
   );

   initial begin
      clk = 1'b0;
      forever #5 clk = ~clk;
   end

   always @(posedge clk) cyc <= cyc + 1;

   ////////////////////////////////////////////////////////////
   // Reference model
   ////////////////////////////////////////////////////////////
   // Wide signed math, truncates toward zero
   function automatic wb_bus_t ref_divide(input div_req_t r);
      logic signed [65:0] a;
      logic signed [65:0] b;
      logic signed [65:0] q;
      logic [31:0]        q32;
      logic               ovfl;
      wb_bus_t            res;
      if (r.is_signed) begin
         a = {{2{r.dividend[63]}}, r.dividend};
         b = {{34{r.divisor[31]}}, r.divisor};
      end else begin
         a = {2'b00, r.dividend};
         b = {34'd0, r.divisor};
      end
      q = a / b;
      if (r.is_signed) begin
         ovfl = (q > 66'sd2147483647) || (q < -66'sd2147483648);
      end else begin
         ovfl = q > 66'sd4294967295;
      end
      // Clamp toward the side that overflowed
      if (!ovfl) begin
         q32 = q[31:0];
      end else if (!r.is_signed) begin
         q32 = umax32;
      end else if (q > 0) begin
         q32 = spos_max32;
      end else begin
         q32 = sneg_min32;
      end
      res.data     = {32'd0, q32};
      res.icc.n    = q32[31];
      res.icc.z    = (q32 == 32'd0);
      res.icc.v    = ovfl;
      res.icc.c    = 1'b0;
      res.xcc.n    = (q < 0);
      res.xcc.z    = (q == 0);
      res.xcc.v    = 1'b0;
      res.xcc.c    = 1'b0;
      res.from_div = 1'b1;
      return res;
   endfunction

   ////////////////////////////////////////////////////////////
   // Result comparison
   ////////////////////////////////////////////////////////////
   // Falling edge, well after the done state settles
   always @(negedge clk) begin : compare_results
      wb_bus_t exp;
      int      t0;
      if (!rst_n || !(wb_req && wb.from_div)) begin
         res_seen = 1'b0;
      end else if (!res_seen) begin
         res_seen = 1'b1;
         results++;
         if (exp_q.size() == 0) begin
            $display("Divide result written at %0t with no divide outstanding", $time);
            errors++;
         end else begin
            exp = exp_q.pop_front();
            t0  = start_q.pop_front();
            checks += 2;
            assert (wb == exp) else begin
               $display("Mismatch at %0t: got %h icc %b xcc %b, expected %h icc %b xcc %b",
                        $time, wb.data, wb.icc, wb.xcc, exp.data, exp.icc, exp.xcc);
               errors++;
            end
            assert (cyc - t0 == wb_lat) else begin
               $display("Mismatch at %0t: result after %0d edges, expected %0d",
                        $time, cyc - t0, wb_lat);
               errors++;
            end
         end
      end
   end

   // Divide acks after ack_delay idle cycles in done
   initial begin : ack_divide
      int waited;
      div_wb_ack = 1'b0;
      waited     = 0;
      forever begin
         @(negedge clk);
         if (wb.from_div && !div_wb_ack) begin
            if (waited >= ack_delay) begin
               div_wb_ack = 1'b1;
            end else begin
               waited++;
            end
         end else begin
            div_wb_ack = 1'b0;
            waited     = 0;
         end
      end
   end

   ////////////////////////////////////////////////////////////
   // Stimulus helpers
   ////////////////////////////////////////////////////////////
   task automatic expect_value(input logic [63:0] got, input logic [63:0] want,
                               input string what);
      checks++;
      assert (got === want) else begin
         $display("Mismatch at %0t: %s is %h, expected %h", $time, what, got, want);
         errors++;
      end
   endtask

   function automatic div_req_t pack_req(input logic [63:0] dvd, input logic [31:0] dvs,
                                         input logic sgn);
      div_req_t r;
      r.dividend  = dvd;
      r.divisor   = dvs;
      r.is_signed = sgn;
      return r;
   endfunction

   // One-cycle start strobe, optionally expecting a result
   task automatic start_divide(input div_req_t r, input bit keep);
      @(negedge clk);
      while (div_busy) @(negedge clk);
      div_start = 1'b1;
      req       = r;
      if (keep) begin
         exp_q.push_back(ref_divide(r));
         start_q.push_back(cyc + 1);
      end
      @(negedge clk);
      div_start = 1'b0;
   endtask

   task automatic run_divide(input logic [63:0] dvd, input logic [31:0] dvs,
                             input logic sgn);
      start_divide(pack_req(dvd, dvs, sgn), 1'b1);
      while (div_busy) @(negedge clk);
   endtask

   task automatic report_test(input string name, input int errs_before);
      if (errors == errs_before) begin
         $display("test %s: ok", name);
      end else begin
         $display("test %s: %0d errors", name, errors - errs_before);
      end
   endtask

   initial begin : watchdog
      repeat (timeout_cyc) @(posedge clk);
      $display("Timeout: run did not finish within %0d cycles", timeout_cyc);
      $display("SIMULATION FAILED");
      $finish;
   end

   ////////////////////////////////////////////////////////////
   // Test sequence
   ////////////////////////////////////////////////////////////
   initial begin
      int          e0;
      logic [31:0] dvs;
      logic [31:0] quo;
      logic [31:0] rmd;
      logic [63:0] dvd;
      void'($urandom(32'ha9bc));
      rst_n      = 1'b0;
      div_start  = 1'b0;
      req        = '0;
      div_kill   = 1'b0;
      mul_done   = 1'b0;
      mul_data   = '0;
      mul_wb_ack = 1'b0;
      repeat (10) @(posedge clk);
      @(negedge clk);
      rst_n = 1'b1;

      e0 = errors;
      @(negedge clk);
      expect_value(div_busy, 1'b0, "div_busy after reset");
      expect_value(wb_req, 1'b0, "wb_req after reset");
      expect_value(mul_stall, 1'b0, "mul_stall after reset");
      report_test("reset", e0);

      // Quotient below 2^32 by construction
      e0 = errors;
      for (int i = 0; i < 40; i++) begin
         dvs = $urandom;
         if (i % 4 == 0) dvs = dvs % 16;
         if (dvs == 32'd0) dvs = 32'd1;
         quo = $urandom;
         rmd = $urandom % dvs;
         run_divide(64'(quo) * 64'(dvs) + 64'(rmd), dvs, 1'b0);
      end
      report_test("unsigned", e0);

      e0 = errors;
      run_divide(64'd100, 32'd7, 1'b1);
      run_divide(-64'sd100, 32'd7, 1'b1);
      run_divide(64'd100, -32'sd7, 1'b1);
      run_divide(-64'sd100, -32'sd7, 1'b1);
      run_divide(64'd5, -32'sd9, 1'b1);
      run_divide(-64'sd5, 32'd9, 1'b1);
      // Exactly -2^31, no overflow
      run_divide(-64'sd6442450944, 32'd3, 1'b1);
      for (int i = 0; i < 20; i++) begin
         dvd = {$urandom, $urandom};
         dvd = 64'($signed(dvd[47:0]));
         dvs = $urandom;
         if (dvs == 32'd0) dvs = 32'd1;
         run_divide(dvd, dvs, 1'b1);
      end
      report_test("signed", e0);

      e0 = errors;
      run_divide(64'h0000_0100_0000_0000, 32'd3, 1'b0);
      run_divide(64'hffff_ffff_ffff_ffff, 32'd1, 1'b0);
      run_divide(64'h0000_0100_0000_0000, 32'd5, 1'b1);
      run_divide(64'h0000_0000_8000_0000, 32'd1, 1'b1);
      run_divide(64'hffff_ff00_0000_0000, 32'd5, 1'b1);
      run_divide(64'h0000_0000_8000_0001, 32'hffff_ffff, 1'b1);
      run_divide(64'h0000_0000_8000_0000, 32'hffff_ffff, 1'b1);
      // Largest negative over minus one
      run_divide(64'h8000_0000_0000_0000, 32'hffff_ffff, 1'b1);
      report_test("overflow", e0);

      // Multiply during run goes straight through
      e0 = errors;
      start_divide(pack_req(64'd1000000007, 32'd13, 1'b0), 1'b1);
      repeat (10) @(negedge clk);
      mul_done = 1'b1;
      mul_data = 64'h0123_4567_89ab_cdef;
      #1;
      expect_value(wb_req, 1'b1, "wb_req for multiply in run");
      expect_value(wb.from_div, 1'b0, "wb.from_div for multiply in run");
      expect_value(wb.data, mul_data, "wb.data for multiply in run");
      expect_value(64'({wb.xcc, wb.icc}), 64'd0, "codes for multiply in run");
      expect_value(mul_stall, 1'b0, "mul_stall in run");
      @(negedge clk);
      mul_wb_ack = 1'b1;
      @(negedge clk);
      mul_wb_ack = 1'b0;
      mul_done   = 1'b0;
      while (div_busy) @(negedge clk);

      // Late multiply stalls behind a held done state
      ack_delay = 3;
      start_divide(pack_req(-64'sd77777777777, 32'd1234, 1'b1), 1'b1);
      repeat (65) @(negedge clk);
      mul_done = 1'b1;
      mul_data = 64'hfeed_0000_beef_0001;
      #1;
      expect_value(mul_stall, 1'b1, "mul_stall in check");
      expect_value(wb_req, 1'b0, "wb_req in check");
      @(negedge clk);
      while (!wb.from_div) @(negedge clk);
      expect_value(mul_stall, 1'b1, "mul_stall during divide writeback");
      while (div_busy) begin
         expect_value(wb.from_div, 1'b1, "port owner while divide is done");
         @(negedge clk);
      end
      expect_value(wb_req, 1'b1, "wb_req for stalled multiply");
      expect_value(wb.from_div, 1'b0, "wb.from_div for stalled multiply");
      expect_value(wb.data, mul_data, "wb.data for stalled multiply");
      expect_value(mul_stall, 1'b0, "mul_stall after divide");
      @(negedge clk);
      mul_wb_ack = 1'b1;
      @(negedge clk);
      mul_wb_ack = 1'b0;
      mul_done   = 1'b0;
      ack_delay  = 0;
      report_test("arbitration", e0);

      e0 = errors;
      start_divide(pack_req(64'd987654321987, 32'd4321, 1'b0), 1'b0);
      repeat (20) @(negedge clk);
      div_kill = 1'b1;
      @(negedge clk);
      div_kill = 1'b0;
      expect_value(div_busy, 1'b0, "div_busy after kill");
      // Room for a stray result to show up
      for (int i = 0; i < 80; i++) begin
         @(negedge clk);
         expect_value(wb_req, 1'b0, "wb_req after kill");
      end
      run_divide(64'd987654321987, 32'd4321, 1'b0);
      report_test("kill", e0);

      if (exp_q.size() != 0) begin
         $display("Divide results missing: %0d never written back", exp_q.size());
         errors++;
      end
      $display("checks %0d, divide results %0d, errors %0d", checks, results, errors);
      if (errors == 0) begin
         $display("SIMULATION PASSED");
      end else begin
         $display("SIMULATION FAILED");
      end
      $finish;
   end

endmodule

// File: flist.f
source/div_pkg.sv
source/div_ctl_fsm.sv
source/div_iter_dp.sv
source/div_ovfl_cc.sv
source/wb_arbiter.sv
source/div_unit_top.sv
testbench/div_unit_chk.sv
testbench/tb_div_unit.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the divide unit testbench with Verilator and run it
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -Wno-fatal --top-module tb_div_unit \
   -f flist.f --Mdir obj_dir -o tb_div_unit \
   || { echo "Verilator build failed"; exit 1; }
out="$(./obj_dir/tb_div_unit 2>&1)"
echo "$out"
echo "$out" | grep -qx "SIMULATION PASSED" && exit 0 || exit 1
